//--- vlog.f
source/rmt_pkg.sv
source/stage_config.sv
source/key_extract.sv
source/match_table.sv
source/action_alu.sv
source/queue_dispatch.sv
source/last_stage.sv
tests/tb_last_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the last_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_last_stage -f vlog.f; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_last_stage 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1

//--- tests/tb_last_stage.sv
module tb_last_stage import rmt_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int table_depth = 8;
    localparam int in_credits  = 4;
    localparam int out_credits = 2;
    // beats over all five tests, sizes the watchdog
    localparam int total_beats = 57;
    localparam int max_cycles  = 20 * total_beats + 200;

    logic                  axis_clk;
    logic                  aresetn;
    phv_t                  phv_in;
    logic                  phv_valid;
    logic                  in_credit;
    cfg_t                  cfg;
    logic                  cfg_valid;
    phv_t                  phv_out;
    logic [num_queues-1:0] out_valid;
    logic [num_queues-1:0] q_credit = '0;

    // reference copy of the stage registers
    key_sel_t m_sel;
    key_t     m_mask;
    entry_t   m_entries [table_depth];
    action_t  m_default;

    phv_t exp_q [num_queues][$];
    int   rcvd [num_queues] = '{default: 0};
    // beats taken before the current rising edge
    int   seen [num_queues] = '{default: 0};
    int   returned [num_queues] = '{default: 0};
    int   sent = 0;
    int   credits_back = 0;
    int   cycles = 0;
    int   test_no = 0;
    bit   quiet = 0;
    bit   slow_ret = 0;
    int   beat_errs = 0;
    int   quiet_errs = 0;
    int   in_errs = 0;
    int   out_errs = 0;
    int   end_errs = 0;

    last_stage #(
        .table_depth(table_depth), .in_credits(in_credits), .out_credits(out_credits)
    ) i_last_stage (
        .axis_clk(axis_clk), .aresetn(aresetn), .phv_in(phv_in), .phv_valid(phv_valid),
        .in_credit(in_credit), .cfg(cfg), .cfg_valid(cfg_valid), .phv_out(phv_out),
        .out_valid(out_valid), .q_credit(q_credit)
    );

    initial begin
        axis_clk = 1'b0;
        forever #4 axis_clk = ~axis_clk;
    end

    // beats taken by the queues and credits handed back to upstream
    always @(posedge axis_clk) begin
        cycles <= cycles + 1;
        if (in_credit) begin
            credits_back <= credits_back + 1;
        end
        for (int q = 0; q < num_queues; q++) begin
            if (out_valid[q]) begin
                rcvd[q] <= rcvd[q] + 1;
            end
        end
    end

    always @(negedge axis_clk) begin
        for (int q = 0; q < num_queues; q++) begin
            seen[q] <= rcvd[q];
            if (rcvd[q] > returned[q] && (!slow_ret || $urandom_range(3) == 0)) begin
                q_credit[q] <= 1'b1;
                returned[q] <= returned[q] + 1;
            end else begin
                q_credit[q] <= 1'b0;
            end
        end
    end

    always @(posedge axis_clk) begin
        if (cycles >= max_cycles) begin
            $display("timeout: pipeline did not drain within %0d cycles", max_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic bit beat_expected(logic [num_queues-1:0] ov, phv_t p);
        bit ok;
        ok = 1'b1;
        for (int q = 0; q < num_queues; q++) begin
            if (ov[q]) begin
                if (seen[q] >= exp_q[q].size()) begin
                    ok = 1'b0;
                end else if (exp_q[q][seen[q]] !== p) begin
                    ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    function automatic bit out_credit_ok();
        for (int q = 0; q < num_queues; q++) begin
            if (rcvd[q] - returned[q] > out_credits) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    a_beat: assert property (@(posedge axis_clk) disable iff (!aresetn)
        out_valid != '0 |-> beat_expected(out_valid, phv_out))
        else begin
            $display("[FAIL] %0d ns: phv on queues %b is not the expected one", $time, out_valid);
            beat_errs++;
        end

    a_quiet: assert property (@(posedge axis_clk) disable iff (!aresetn)
        quiet |-> (out_valid == '0 && !in_credit))
        else begin
            $display("[FAIL] %0d ns: output activity with no input", $time);
            quiet_errs++;
        end

    a_in_credit: assert property (@(posedge axis_clk) disable iff (!aresetn)
        credits_back <= sent)
        else begin
            $display("[FAIL] %0d ns: ingress credits %0d for %0d sent", $time,
                credits_back, sent);
            in_errs++;
        end

    a_out_credit: assert property (@(posedge axis_clk) disable iff (!aresetn)
        out_credit_ok())
        else begin
            $display("[FAIL] %0d ns: a queue holds more than %0d beats", $time, out_credits);
            out_errs++;
        end

    function automatic phv_t predict(phv_t p);
        key_t    k;
        action_t a;
        phv_t    r;
        bit      found;
        k.f0  = p.fields[m_sel[0]] & m_mask.f0;
        k.f1  = p.fields[m_sel[1]] & m_mask.f1;
        a     = m_default;
        found = 1'b0;
        for (int i = 0; i < table_depth; i++) begin
            if (!found && m_entries[i].valid && m_entries[i].key == k) begin
                a     = m_entries[i].action;
                found = 1'b1;
            end
        end
        r = p;
        case (a.op)
            act_set:  r.fields[a.dst] = a.imm;
            act_add:  r.fields[a.dst] = p.fields[a.dst] + a.imm;
            act_sub:  r.fields[a.dst] = p.fields[a.dst] - a.imm;
            act_drop: r.discard = 1'b1;
            default: begin
            end
        endcase
        if (a.op != act_drop) begin
            r.qmap = a.qmap;
        end
        return r;
    endfunction

    function automatic phv_t random_phv();
        phv_t p;
        for (int i = 0; i < num_fields; i++) begin
            p.fields[i] = field_w'($urandom);
        end
        p.qmap    = num_queues'($urandom);
        p.discard = 1'b0;
        return p;
    endfunction

    // random phv whose masked key equals the key of entry e
    function automatic phv_t hit_phv(int e);
        phv_t p;
        p = random_phv();
        p.fields[m_sel[0]] = (p.fields[m_sel[0]] & ~m_mask.f0) | m_entries[e].key.f0;
        p.fields[m_sel[1]] = (p.fields[m_sel[1]] & ~m_mask.f1) | m_entries[e].key.f1;
        return p;
    endfunction

    task automatic send(phv_t p);
        phv_t r;
        while (sent - credits_back >= in_credits) begin
            @(negedge axis_clk);
        end
        r = predict(p);
        if (!r.discard && r.qmap != '0) begin
            for (int q = 0; q < num_queues; q++) begin
                if (r.qmap[q]) begin
                    exp_q[q].push_back(r);
                end
            end
        end
        phv_in    = p;
        phv_valid = 1'b1;
        sent++;
        @(negedge axis_clk);
        phv_valid = 1'b0;
    endtask

    task automatic apply_cfg(cfg_t c);
        cfg       = c;
        cfg_valid = 1'b1;
        @(negedge axis_clk);
        cfg_valid = 1'b0;
    endtask

    task automatic write_entry(int idx, logic [15:0] k0, logic [15:0] k1, act_op_e op,
                               int dst, logic [15:0] imm, logic [3:0] qmap);
        entry_t e;
        cfg_t   c;
        e.valid       = 1'b1;
        e.key.f0      = k0;
        e.key.f1      = k1;
        e.action.op   = op;
        e.action.dst  = field_idx_t'(dst);
        e.action.imm  = imm;
        e.action.qmap = qmap;
        m_entries[idx] = e;
        c       = '0;
        c.op    = cfg_entry;
        c.index = 3'(idx);
        c.entry = e;
        apply_cfg(c);
    endtask

    function automatic bit drained();
        for (int q = 0; q < num_queues; q++) begin
            if (rcvd[q] != exp_q[q].size()) begin
                return 1'b0;
            end
        end
        return credits_back == sent;
    endfunction

    task automatic finish_test(string name);
        while (!drained()) begin
            @(negedge axis_clk);
        end
        repeat (8) @(negedge axis_clk);
        assert (drained()) else begin
            $display("extra beats or ingress credits appeared after the pipeline drained");
            end_errs++;
        end
        test_no++;
        $display("test %0d %s: done, %0d errors so far", test_no, name,
            beat_errs + quiet_errs + in_errs + out_errs + end_errs);
    endtask

    initial begin
        cfg_t c;
        int   r;
        void'($urandom(13074));
        aresetn   = 1'b0;
        phv_in    = '0;
        phv_valid = 1'b0;
        cfg       = '0;
        cfg_valid = 1'b0;
        m_sel[0]  = 2'd0;
        m_sel[1]  = 2'd1;
        m_mask    = '1;
        m_default = '{op: act_nop, dst: 2'd0, imm: '0, qmap: 4'b0001};
        for (int i = 0; i < table_depth; i++) begin
            m_entries[i] = '0;
        end
        repeat (2) @(posedge axis_clk);
        @(negedge axis_clk);
        aresetn = 1'b1;

        quiet = 1'b1;
        repeat (10) @(negedge axis_clk);
        quiet = 1'b0;
        send(random_phv());
        finish_test("reset defaults");

        // key from fields 2 and 3, low byte of field 2 only
        m_sel[0]  = 2'd2;
        m_sel[1]  = 2'd3;
        m_mask.f0 = 16'h00ff;
        m_mask.f1 = 16'hffff;
        c         = '0;
        c.op      = cfg_key_sel;
        c.sel     = m_sel;
        apply_cfg(c);
        c.op      = cfg_key_mask;
        c.mask    = m_mask;
        apply_cfg(c);
        write_entry(0, 16'h0011, 16'h2222, act_set, 0, 16'hbeef, 4'b0011);
        write_entry(1, 16'h0022, 16'h3333, act_add, 1, 16'h0005, 4'b1110);
        write_entry(2, 16'h0033, 16'h4444, act_sub, 3, 16'h0007, 4'b1111);
        for (int i = 0; i < 6; i++) begin
            send(hit_phv(i % 3));
        end
        finish_test("set add sub and multicast");

        m_default      = '{op: act_add, dst: 2'd2, imm: 16'h0001, qmap: 4'b0100};
        c              = '0;
        c.op           = cfg_default;
        c.entry.action = m_default;
        apply_cfg(c);
        write_entry(3, 16'h0022, 16'h3333, act_set, 2, 16'h1234, 4'b0001);
        write_entry(4, 16'h0044, 16'h5555, act_set, 1, 16'h0abc, 4'b1000);
        write_entry(5, 16'h0044, 16'h5555, act_sub, 0, 16'h0100, 4'b0001);
        for (int i = 0; i < 2; i++) begin
            send(random_phv());
            send(hit_phv(3));
            send(hit_phv(5));
        end
        finish_test("default action and priority");

        write_entry(6, 16'h0066, 16'h7777, act_drop, 0, 16'h0000, 4'b1111);
        write_entry(7, 16'h0077, 16'h8888, act_set, 0, 16'h5a5a, 4'b0000);
        for (int i = 0; i < 4; i++) begin
            send(hit_phv(6 + i % 2));
        end
        finish_test("drop and empty qmap");

        slow_ret = 1'b1;
        for (int i = 0; i < 40; i++) begin
            r = $urandom_range(9);
            if (r < 8) begin
                send(hit_phv(r));
            end else begin
                send(random_phv());
            end
        end
        finish_test("slow random credit return");

        $display("tests: %0d, beats sent: %0d, errors: %0d", test_no, sent,
            beat_errs + quiet_errs + in_errs + out_errs + end_errs);
        if (beat_errs + quiet_errs + in_errs + out_errs + end_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- source/last_stage.sv
module last_stage import rmt_pkg::*; #(
    parameter int table_depth = 8,
    parameter int in_credits  = 4,
    parameter int out_credits = 2
) (
    input  logic                  axis_clk,
    input  logic                  aresetn,
    input  phv_t                  phv_in,
    input  logic                  phv_valid,
    output logic                  in_credit,
    input  cfg_t                  cfg,
    input  logic                  cfg_valid,
    output phv_t                  phv_out,
    output logic [num_queues-1:0] out_valid,
    input  logic [num_queues-1:0] q_credit
);

    key_sel_t                 key_sel;
    key_t                     key_mask;
    entry_t [table_depth-1:0] entries;
    action_t                  default_act;
    logic                     stall;

    phv_t    ke_phv;
    key_t    ke_key;
    logic    ke_valid;
    phv_t    mt_phv;
    action_t mt_action;
    logic    mt_valid;
    phv_t    alu_phv;
    logic    alu_valid;

    stage_config #(.table_depth(table_depth)) i_stage_config (
        .axis_clk(axis_clk), .aresetn(aresetn), .cfg_valid(cfg_valid), .cfg(cfg),
        .key_sel(key_sel), .key_mask(key_mask), .entries(entries), .default_act(default_act)
    );

    key_extract #(.in_credits(in_credits)) i_key_extract (
        .axis_clk(axis_clk), .aresetn(aresetn), .phv_valid(phv_valid), .stall(stall),
        .phv_in(phv_in), .key_sel(key_sel), .key_mask(key_mask), .in_credit(in_credit),
        .phv(ke_phv), .key(ke_key), .valid(ke_valid)
    );

    match_table #(.table_depth(table_depth)) i_match_table (
        .axis_clk(axis_clk), .aresetn(aresetn), .valid_in(ke_valid), .stall(stall),
        .phv_in(ke_phv), .key(ke_key), .entries(entries), .default_act(default_act),
        .phv(mt_phv), .action(mt_action), .valid(mt_valid)
    );

    action_alu i_action_alu (
        .axis_clk(axis_clk), .aresetn(aresetn), .valid_in(mt_valid), .stall(stall),
        .phv_in(mt_phv), .action(mt_action), .phv(alu_phv), .valid(alu_valid)
    );

    queue_dispatch #(.out_credits(out_credits)) i_queue_dispatch (
        .axis_clk(axis_clk), .aresetn(aresetn), .valid_in(alu_valid), .q_credit(q_credit),
        .phv_in(alu_phv), .stall(stall), .phv_out(phv_out), .out_valid(out_valid)
    );

endmodule

//--- source/queue_dispatch.sv
module queue_dispatch import rmt_pkg::*; #(
    parameter int out_credits = 2
) (
    input  logic                  axis_clk,
    input  logic                  aresetn,
    input  logic                  valid_in,
    input  logic [num_queues-1:0] q_credit,
    input  phv_t                  phv_in,
    output logic                  stall,
    output phv_t                  phv_out,
    output logic [num_queues-1:0] out_valid
);

    // one spare bit so an overflow shows up in the range check
    localparam int cnt_w = $clog2(out_credits + 1) + 1;

    phv_t                  hold;
    logic                  hold_valid;
    logic [cnt_w-1:0]      cnt [num_queues];
    logic [num_queues-1:0] has_credit;
    logic                  drop;
    logic                  ready;

    always_comb begin
        for (int q = 0; q < num_queues; q++) begin
            has_credit[q] = cnt[q] != '0;
        end
    end

    assign drop      = hold.discard || hold.qmap == '0;
    assign ready     = (hold.qmap & ~has_credit) == '0;
    // multicast goes out whole, never split across cycles
    assign out_valid = (hold_valid && !drop && ready) ? hold.qmap : '0;
    assign stall     = hold_valid && !drop && !ready;
    assign phv_out   = hold;

    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            hold_valid <= 1'b0;
            for (int q = 0; q < num_queues; q++) begin
                cnt[q] <= cnt_w'(out_credits);
            end
        end else begin
            if (!stall) begin
                hold_valid <= valid_in;
            end
            for (int q = 0; q < num_queues; q++) begin
                cnt[q] <= cnt[q] + cnt_w'(q_credit[q]) - cnt_w'(out_valid[q]);
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!stall) begin
            hold <= phv_in;
        end
    end

    for (genvar q = 0; q < num_queues; q++) begin : g_credit_chk
        a_cnt_range: assert property (@(posedge axis_clk) disable iff (!aresetn)
            cnt[q] <= cnt_w'(out_credits))
            else $error("queue %0d returned more credits than it was given", q);
    end

endmodule

//--- source/action_alu.sv
module action_alu import rmt_pkg::*; (
    input  logic    axis_clk,
    input  logic    aresetn,
    input  logic    valid_in,
    input  logic    stall,
    input  phv_t    phv_in,
    input  action_t action,
    output phv_t    phv,
    output logic    valid
);

    phv_t nxt;

    always_comb begin
        nxt = phv_in;
        case (action.op)
            act_set: begin
                nxt.fields[action.dst] = action.imm;
            end
            act_add: begin
                nxt.fields[action.dst] = phv_in.fields[action.dst] + action.imm;
            end
            act_sub: begin
                nxt.fields[action.dst] = phv_in.fields[action.dst] - action.imm;
            end
            act_drop: begin
                nxt.discard = 1'b1;
            end
            default: begin
            end
        endcase
        // a dropped phv keeps its old destinations
        if (action.op != act_drop) begin
            nxt.qmap = action.qmap;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            valid <= 1'b0;
        end else if (!stall) begin
            valid <= valid_in;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!stall) begin
            phv <= nxt;
        end
    end

endmodule

//--- source/match_table.sv
module match_table import rmt_pkg::*; #(
    parameter int table_depth = 8
) (
    input  logic                     axis_clk,
    input  logic                     aresetn,
    input  logic                     valid_in,
    input  logic                     stall,
    input  phv_t                     phv_in,
    input  key_t                     key,
    input  entry_t [table_depth-1:0] entries,
    input  action_t                  default_act,
    output phv_t                     phv,
    output action_t                  action,
    output logic                     valid
);

    action_t hit_act;

    // walk down from the top so the lowest index wins
    always_comb begin
        hit_act = default_act;
        for (int i = table_depth - 1; i >= 0; i--) begin
            if (entries[i].valid && entries[i].key == key) begin
                hit_act = entries[i].action;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            valid <= 1'b0;
        end else if (!stall) begin
            valid <= valid_in;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!stall) begin
            phv    <= phv_in;
            action <= hit_act;
        end
    end

endmodule

//--- source/key_extract.sv
module key_extract import rmt_pkg::*; #(
    parameter int in_credits = 4
) (
    input  logic     axis_clk,
    input  logic     aresetn,
    input  logic     phv_valid,
    input  logic     stall,
    input  phv_t     phv_in,
    input  key_sel_t key_sel,
    input  key_t     key_mask,
    output logic     in_credit,
    output phv_t     phv,
    output key_t     key,
    output logic     valid
);

    localparam int ptr_w = (in_credits > 1) ? $clog2(in_credits) : 1;
    localparam int cnt_w = $clog2(in_credits + 1);

    phv_t             fifo [in_credits];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             pop;
    phv_t             head;
    key_t             sel_key;

    assign head      = fifo[rd_ptr];
    assign pop       = !stall && count != '0;
    assign in_credit = pop;

    always_comb begin
        sel_key.f0 = head.fields[key_sel[0]];
        sel_key.f1 = head.fields[key_sel[1]];
    end

    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            if (phv_valid) begin
                wr_ptr <= (wr_ptr == ptr_w'(in_credits - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(in_credits - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(phv_valid) - cnt_w'(pop);
            if (!stall) begin
                valid <= pop;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (phv_valid) begin
            fifo[wr_ptr] <= phv_in;
        end
        if (pop) begin
            phv <= head;
            key <= sel_key & key_mask;
        end
    end

    // upstream may only send while holding a credit
    a_credit_overrun: assert property (@(posedge axis_clk) disable iff (!aresetn)
        phv_valid |-> count != cnt_w'(in_credits))
        else $error("ingress write into full buffer");

endmodule

//--- source/stage_config.sv
module stage_config import rmt_pkg::*; #(
    parameter int table_depth = 8
) (
    input  logic                        axis_clk,
    input  logic                        aresetn,
    input  logic                        cfg_valid,
    input  cfg_t                        cfg,
    output key_sel_t                    key_sel,
    output key_t                        key_mask,
    output entry_t [table_depth-1:0]    entries,
    output action_t                     default_act
);

    logic index_ok;

    assign index_ok = int'(cfg.index) < table_depth;

    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            key_sel[0]       <= 2'd0;
            key_sel[1]       <= 2'd1;
            key_mask         <= '1;
            entries          <= '0;
            default_act.op   <= act_nop;
            default_act.dst  <= '0;
            default_act.imm  <= '0;
            default_act.qmap <= 4'b0001;
        end else if (cfg_valid) begin
            case (cfg.op)
                cfg_key_sel: begin
                    key_sel <= cfg.sel;
                end
                cfg_key_mask: begin
                    key_mask <= cfg.mask;
                end
                cfg_entry: begin
                    // slots past the table are ignored
                    if (index_ok) begin
                        entries[cfg.index] <= cfg.entry;
                    end
                end
                cfg_default: begin
                    default_act <= cfg.entry.action;
                end
                default: begin
                end
            endcase
        end
    end

    // host must stay inside the table
    a_entry_index: assert property (@(posedge axis_clk) disable iff (!aresetn)
        (cfg_valid && cfg.op == cfg_entry) |-> index_ok)
        else $error("config entry index %0d beyond table depth %0d", cfg.index, table_depth);

endmodule

//--- source/rmt_pkg.sv
package rmt_pkg;

    localparam int field_w    = 16;
    localparam int num_fields = 4;
    localparam int num_queues = 4;

    typedef logic [1:0] field_idx_t;

    // two selected fields feed the key
    typedef field_idx_t [1:0] key_sel_t;

    typedef struct packed {
        logic [num_fields-1:0][field_w-1:0] fields;
        logic [num_queues-1:0]              qmap;
        logic                               discard;
    } phv_t;

    typedef struct packed {
        logic [field_w-1:0] f1;
        logic [field_w-1:0] f0;
    } key_t;

    typedef enum logic [2:0] {act_nop, act_set, act_add, act_sub, act_drop} act_op_e;

    typedef struct packed {
        act_op_e               op;
        field_idx_t            dst;
        logic [field_w-1:0]    imm;
        logic [num_queues-1:0] qmap;
    } action_t;

    typedef struct packed {
        logic    valid;
        key_t    key;
        action_t action;
    } entry_t;

    typedef enum logic [1:0] {cfg_key_sel, cfg_key_mask, cfg_entry, cfg_default} cfg_op_e;

    // cfg_default takes its action from entry.action
    typedef struct packed {
        cfg_op_e    op;
        logic [2:0] index;
        key_sel_t   sel;
        key_t       mask;
        entry_t     entry;
    } cfg_t;

endpackage
